// File: common/life_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// board geometry defaults for the row streaming Life engine
// top level reads these to set WIDTH, DEPTH and GENS on its children
////////////////////////////////////////////////////////////////////////////

package life_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// geometry
	////////////////////////////////////////////////////////////////////////////

	// one row is one RAM word
	localparam int WIDTH_DEF = 16;	// cells per row
	localparam int DEPTH_DEF = 16;	// rows per board, torus in both directions
	localparam int GENS_DEF  = 2;	// chained generation stages, 1 to 3

	// row address width follows the board depth
	localparam int ABITS = $clog2(DEPTH_DEF);

	////////////////////////////////////////////////////////////////////////////
	// derived types
	////////////////////////////////////////////////////////////////////////////

	// bit x of a row is column x
	// column 0 neighbours column WIDTH_DEF-1
	typedef logic [WIDTH_DEF-1:0] row_t;

	// row index inside one bank
	// bank select sits above it in the RAM
	typedef logic [ABITS-1:0] addr_t;

endpackage

// File: common/life_cmd_pkg.sv
////////////////////////////////////////////////////////////////////////////
// host command opcodes and sequencer FSM states
////////////////////////////////////////////////////////////////////////////

package life_cmd_pkg;

	// host command port opcodes
	typedef enum logic [1:0] {
		op_nop   = 2'd0,	// accepted and ignored
		op_write = 2'd1,	// cmd_data into current bank at cmd_addr
		op_read  = 2'd2,	// row of current bank back on rsp_data
		op_step  = 2'd3		// one pass of GENS generations
	} cmd_op_e;

	// row sequencer FSM
	// cmd_ready is high only in st_idle
	typedef enum logic [1:0] {
		st_idle   = 2'd0,	// taking commands
		st_stream = 2'd1,	// one row read per cycle
		st_drain  = 2'd2	// reads done, writeback still busy
	} seq_state_e;

endpackage

// File: rtl/cell_ram.sv
////////////////////////////////////////////////////////////////////////////
// two bank board RAM with one registered read port and one write port
// host writes and writeback writes share the write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module cell_ram #(
	parameter int WIDTH = 16,	// row width
	parameter int DEPTH = 16	// rows per bank
) (
	input  logic                 clk,
	input  logic                 rd_en,
	input  logic                 rd_bank,
	input  life_cfg_pkg::addr_t  rd_addr,
	output logic [WIDTH-1:0]     rd_row,		// valid the cycle after rd_en
	input  logic                 host_we,
	input  life_cfg_pkg::addr_t  host_addr,
	input  logic [WIDTH-1:0]     host_row,
	input  logic                 wb_we,
	input  logic                 wb_bank,
	input  life_cfg_pkg::addr_t  wb_addr,
	input  logic [WIDTH-1:0]     wb_row,
	input  logic                 cur_bank		// host writes land here
);

	// bank is the top address bit
	logic [WIDTH-1:0] mem [0:2*DEPTH-1];

	logic                            we;
	logic [life_cfg_pkg::ABITS:0]    wr_idx;
	logic [WIDTH-1:0]                wr_row;

	// merge write sources, host only ever writes while idle
	assign we     = host_we | wb_we;
	assign wr_idx = host_we ? {cur_bank, host_addr} : {wb_bank, wb_addr};
	assign wr_row = host_we ? host_row : wb_row;

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_idx] <= wr_row;
		if (rd_en)
			rd_row <= mem[{rd_bank, rd_addr}];	// registered read
	end

endmodule

// File: rtl/row_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// command FSM and row read order for step passes
// owns the current bank bit, flipped when writeback finishes a pass
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module row_sequencer #(
	parameter int WIDTH = 16,	// row width
	parameter int DEPTH = 16,	// board rows
	parameter int GENS  = 2		// generation stages in the chain
) (
	input  logic                  clk,
	input  logic                  rst,
	// host command port
	input  logic                  cmd_valid,
	input  life_cmd_pkg::cmd_op_e cmd_op,
	input  life_cfg_pkg::addr_t   cmd_addr,
	input  logic [WIDTH-1:0]      cmd_data,
	output logic                  cmd_ready,
	output logic                  rsp_valid,
	output logic [WIDTH-1:0]      rsp_data,
	// RAM read port
	output logic                  rd_en,
	output logic                  rd_bank,
	output life_cfg_pkg::addr_t   rd_addr,
	input  logic [WIDTH-1:0]      rd_row,
	// RAM host write
	output logic                  host_we,
	output life_cfg_pkg::addr_t   host_addr,
	output logic [WIDTH-1:0]      host_row,
	// stream markers into first stage
	output logic                  in_valid,
	output logic                  in_first,
	// writeback handshake
	input  logic                  bank_flip,
	output logic                  cur_bank
);

	// each stage eats one row at either end, so read GENS extra on both sides
	localparam int NREADS = DEPTH + 2*GENS;
	localparam int CW     = $clog2(NREADS + 1);
	localparam life_cfg_pkg::addr_t START_ROW = life_cfg_pkg::addr_t'(DEPTH - GENS);

	life_cmd_pkg::seq_state_e state;
	logic [CW-1:0]            cnt;		// reads issued this pass
	life_cfg_pkg::addr_t      row_ptr;	// next row to read, wraps at DEPTH
	logic                     rd_pend;	// host read in RAM
	logic                     accept;
	logic                     host_rd;
	logic                     streaming;

	assign cmd_ready = (state == life_cmd_pkg::st_idle);
	assign accept    = cmd_valid & cmd_ready;
	assign host_rd   = accept && (cmd_op == life_cmd_pkg::op_read);
	assign streaming = (state == life_cmd_pkg::st_stream);

	// read port shared by host reads and the stream
	assign rd_en   = host_rd | streaming;
	assign rd_bank = cur_bank;
	assign rd_addr = streaming ? row_ptr : cmd_addr;

	// host write, only possible while idle
	assign host_we   = accept && (cmd_op == life_cmd_pkg::op_write);
	assign host_addr = cmd_addr;
	assign host_row  = cmd_data;

	////////////////////////////////////////////////////////////////////////////
	// FSM and stream counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= life_cmd_pkg::st_idle;
			cur_bank  <= 1'b0;
			cnt       <= '0;
			row_ptr   <= '0;
			rd_pend   <= 1'b0;
			rsp_valid <= 1'b0;
			in_valid  <= 1'b0;
			in_first  <= 1'b0;
		end else begin
			rd_pend   <= host_rd;	// RAM cycle
			rsp_valid <= rd_pend;	// output register cycle
			// markers ride one cycle behind the read, in step with rd_row
			in_valid  <= streaming;
			in_first  <= streaming && (cnt == '0);
			case (state)
				life_cmd_pkg::st_idle: begin
					if (accept && (cmd_op == life_cmd_pkg::op_step)) begin
						state   <= life_cmd_pkg::st_stream;
						cnt     <= '0;
						row_ptr <= START_ROW;	// GENS rows above row 0
					end
				end
				life_cmd_pkg::st_stream: begin
					cnt     <= cnt + 1'b1;
					row_ptr <= (row_ptr == life_cfg_pkg::addr_t'(DEPTH - 1)) ?
						'0 : row_ptr + 1'b1;	// torus wrap
					if (cnt == CW'(NREADS - 1))
						state <= life_cmd_pkg::st_drain;
				end
				life_cmd_pkg::st_drain: begin
					if (bank_flip) begin	// new board complete in other bank
						cur_bank <= ~cur_bank;
						state    <= life_cmd_pkg::st_idle;
					end
				end
				default: state <= life_cmd_pkg::st_idle;
			endcase
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (rd_pend)
			rsp_data <= rd_row;
	end

endmodule

// File: life_core/life_gen_stage.sv
////////////////////////////////////////////////////////////////////////////
// one Life generation over a gapless stream of rows
// emits one row fewer at each end of a pass, two cycles of latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module life_gen_stage #(
	parameter int WIDTH = 16	// cells per row
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  logic             in_first,	// first row of a pass
	input  logic [WIDTH-1:0] in_row,
	output logic             out_valid,
	output logic             out_first,
	output logic [WIDTH-1:0] out_row
);

	// window is in_row plus the two rows before it
	logic [WIDTH-1:0] win1;	// previous row, centre of the window
	logic [WIDTH-1:0] win2;	// oldest row
	logic [1:0]       fill;	// rows held since in_first, saturates at 3
	logic             full;	// in_row completes a window
	logic             full_first;

	// stage 1 registers
	logic [WIDTH-1:0][1:0] vsum;	// column sums 0..3
	logic [WIDTH-1:0]      mid;		// centre row kept for the rule
	logic                  v1_valid;
	logic                  v1_first;

	// stage 2 combinational
	logic [WIDTH-1:0][3:0] add9;	// 3x3 totals 0..9
	logic [WIDTH-1:0]      next;

	assign full       = in_valid && !in_first && (fill >= 2'd2);
	assign full_first = full && (fill == 2'd2);	// third row of the pass

	////////////////////////////////////////////////////////////////////////////
	// window shift and vertical sums
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			fill     <= '0;
			v1_valid <= 1'b0;
			v1_first <= 1'b0;
		end else begin
			if (in_valid)
				fill <= in_first ? 2'd1 : ((fill == 2'd3) ? fill : fill + 1'b1);
			v1_valid <= full;
			v1_first <= full_first;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			win2 <= win1;
			win1 <= in_row;
		end
		for (int x = 0; x < WIDTH; x++)
			vsum[x] <= {1'b0, win2[x]} + {1'b0, win1[x]} + {1'b0, in_row[x]};
		mid <= win1;
	end

	////////////////////////////////////////////////////////////////////////////
	// horizontal sum with wrap and the rule
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		int xl;
		int xr;
		for (int x = 0; x < WIDTH; x++) begin
			xl = (x == 0) ? WIDTH - 1 : x - 1;	// left wrap
			xr = (x == WIDTH - 1) ? 0 : x + 1;	// right wrap
			add9[x] = {2'b00, vsum[xl]} + {2'b00, vsum[x]} + {2'b00, vsum[xr]};
			// total counts the cell itself
			next[x] = (add9[x] == 4'd3) || ((add9[x] == 4'd4) && mid[x]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_first <= 1'b0;
		end else begin
			out_valid <= v1_valid;
			out_first <= v1_first;
		end
	end

	always_ff @(posedge clk)
		out_row <= next;

endmodule

// File: life_core/row_writeback.sv
////////////////////////////////////////////////////////////////////////////
// writes result rows of a pass into the bank not being read
// pulses bank_flip with the last row of the board
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module row_writeback #(
	parameter int WIDTH = 16,	// cells per row
	parameter int DEPTH = 16	// rows per board
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                out_valid,
	input  logic                out_first,	// result row 0
	input  logic [WIDTH-1:0]    out_row,
	input  logic                cur_bank,
	output logic                wb_we,
	output logic                wb_bank,
	output life_cfg_pkg::addr_t wb_addr,
	output logic [WIDTH-1:0]    wb_row,
	output logic                bank_flip
);

	life_cfg_pkg::addr_t addr_cnt;	// next row to write
	life_cfg_pkg::addr_t this_addr;

	// restart at row 0 on each pass
	assign this_addr = out_first ? '0 : addr_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			addr_cnt  <= '0;
			wb_we     <= 1'b0;
			bank_flip <= 1'b0;
		end else begin
			wb_we     <= out_valid;
			// DEPTH-th write of the pass, alongside the last wb_we
			bank_flip <= out_valid && (this_addr == life_cfg_pkg::addr_t'(DEPTH - 1));
			if (out_valid)
				addr_cnt <= this_addr + 1'b1;
		end
	end

	// payload, qualified by wb_we
	always_ff @(posedge clk) begin
		if (out_valid) begin
			wb_addr <= this_addr;
			wb_row  <= out_row;
			wb_bank <= ~cur_bank;	// inactive bank
		end
	end

endmodule

// File: rtl/life_engine_top.sv
////////////////////////////////////////////////////////////////////////////
// Life engine top, host command port over a two bank torus board
// step passes stream rows through GENS stages into the other bank
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module life_engine_top #(
	parameter int WIDTH = life_cfg_pkg::WIDTH_DEF,
	parameter int DEPTH = life_cfg_pkg::DEPTH_DEF,
	parameter int GENS  = life_cfg_pkg::GENS_DEF
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cmd_valid,
	input  life_cmd_pkg::cmd_op_e cmd_op,
	input  life_cfg_pkg::addr_t   cmd_addr,
	input  life_cfg_pkg::row_t    cmd_data,
	output logic                  cmd_ready,
	output logic                  rsp_valid,
	output life_cfg_pkg::row_t    rsp_data
);

	// read port
	logic                rd_en;
	logic                rd_bank;
	life_cfg_pkg::addr_t rd_addr;
	// host write
	logic                host_we;
	life_cfg_pkg::addr_t host_addr;
	logic [WIDTH-1:0]    host_row;
	// writeback
	logic                wb_we;
	logic                wb_bank;
	life_cfg_pkg::addr_t wb_addr;
	logic [WIDTH-1:0]    wb_row;
	logic                bank_flip;
	logic                cur_bank;

	// stage chain, index 0 is RAM data, index GENS is the last result
	logic             s_valid [0:GENS];
	logic             s_first [0:GENS];
	logic [WIDTH-1:0] s_row   [0:GENS];

	row_sequencer #(.WIDTH(WIDTH), .DEPTH(DEPTH), .GENS(GENS)) u_seq (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.cmd_ready(cmd_ready), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
		.rd_en(rd_en), .rd_bank(rd_bank), .rd_addr(rd_addr), .rd_row(s_row[0]),
		.host_we(host_we), .host_addr(host_addr), .host_row(host_row),
		.in_valid(s_valid[0]), .in_first(s_first[0]),
		.bank_flip(bank_flip), .cur_bank(cur_bank)
	);

	cell_ram #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_ram (
		.clk(clk),
		.rd_en(rd_en), .rd_bank(rd_bank), .rd_addr(rd_addr), .rd_row(s_row[0]),
		.host_we(host_we), .host_addr(host_addr), .host_row(host_row),
		.wb_we(wb_we), .wb_bank(wb_bank), .wb_addr(wb_addr), .wb_row(wb_row),
		.cur_bank(cur_bank)
	);

	// one generation per stage
	for (genvar g = 0; g < GENS; g++) begin : gen_stage
		life_gen_stage #(.WIDTH(WIDTH)) u_stage (
			.clk(clk), .rst(rst),
			.in_valid(s_valid[g]), .in_first(s_first[g]), .in_row(s_row[g]),
			.out_valid(s_valid[g+1]), .out_first(s_first[g+1]), .out_row(s_row[g+1])
		);
	end

	row_writeback #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_wb (
		.clk(clk), .rst(rst),
		.out_valid(s_valid[GENS]), .out_first(s_first[GENS]), .out_row(s_row[GENS]),
		.cur_bank(cur_bank),
		.wb_we(wb_we), .wb_bank(wb_bank), .wb_addr(wb_addr), .wb_row(wb_row),
		.bank_flip(bank_flip)
	);

endmodule

// File: verification/life_properties.sv
////////////////////////////////////////////////////////////////////////////
// protocol assertions on the row sequencer, attached by bind
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module life_properties (
	input logic                     clk,
	input logic                     rst,
	input logic                     cmd_valid,
	input logic                     cmd_ready,
	input logic                     rsp_valid,
	input logic                     host_we,
	input logic                     bank_flip,
	input life_cmd_pkg::cmd_op_e    cmd_op,
	input life_cmd_pkg::seq_state_e state
);

	logic rd_accept;	// op_read taken this cycle

	assign rd_accept = cmd_valid && cmd_ready && (cmd_op == life_cmd_pkg::op_read);

	// RAM cycle plus output register
	a_rsp_after_read: assert property (@(posedge clk) disable iff (rst)
		rd_accept |-> ##2 rsp_valid)
		else $error("rsp_valid missing two cycles after an accepted op_read");

	a_rsp_has_read: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |-> $past(rd_accept, 2))
		else $error("rsp_valid without an op_read two cycles earlier");

	// busy FSM frees the port only after the writeback's bank_flip
	a_ready_busy: assert property (@(posedge clk) disable iff (rst)
		((state != life_cmd_pkg::st_idle) && !bank_flip) |=> !cmd_ready)
		else $error("cmd_ready rose while a pass was still running");

	// last writeback row and a host write would share the RAM write port
	a_host_we_flip: assert property (@(posedge clk) disable iff (rst)
		host_we |-> !bank_flip)
		else $error("host write in the same cycle as the end of a pass");

endmodule

bind row_sequencer life_properties u_props (
	.clk(clk), .rst(rst),
	.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .rsp_valid(rsp_valid),
	.host_we(host_we), .bank_flip(bank_flip), .cmd_op(cmd_op), .state(state)
);

// File: verification/life_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the Life engine, table of host commands applied in a loop
// expected rows come from a shadow board stepped by a torus Life model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module life_tb;

	localparam int W        = life_cfg_pkg::WIDTH_DEF;
	localparam int D        = life_cfg_pkg::DEPTH_DEF;
	localparam int G        = life_cfg_pkg::GENS_DEF;
	localparam int PASS_MAX = D + 4*G + 4;	// step pass bound in cycles
	localparam int NT       = 256;			// table capacity

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  cmd_valid;
	life_cmd_pkg::cmd_op_e cmd_op;
	life_cfg_pkg::addr_t   cmd_addr;
	life_cfg_pkg::row_t    cmd_data;
	logic                  cmd_ready;
	logic                  rsp_valid;
	life_cfg_pkg::row_t    rsp_data;

	// stimulus table, one entry per test
	string                 t_name  [0:NT-1];
	life_cmd_pkg::cmd_op_e t_op    [0:NT-1];
	life_cfg_pkg::addr_t   t_addr  [0:NT-1];
	life_cfg_pkg::row_t    t_data  [0:NT-1];
	life_cfg_pkg::row_t    t_exp   [0:NT-1];
	logic                  t_stall [0:NT-1];	// must wait out a running pass
	int                    n_tests = 0;

	life_cfg_pkg::row_t shadow [0:D-1];	// model of the current bank
	logic [31:0]        lfsr = 32'hfb7d;
	int                 cycles = 0;
	int                 cycle_limit = 1000000;	// rearmed once the table exists
	int                 errors = 0;

	life_engine_top DUT (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.cmd_ready(cmd_ready), .rsp_valid(rsp_valid), .rsp_data(rsp_data)
	);

	always #20 clk = ~clk;	// 40 ns period

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// random rows and the Life model
	////////////////////////////////////////////////////////////////////////////

	// fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic life_cfg_pkg::row_t random_row();
		life_cfg_pkg::row_t r;
		for (int x = 0; x < W; x++)
			r[x] = lfsr_bit();
		return r;
	endfunction

	// one generation on the torus, eight neighbours counted
	function automatic void life_generation();
		life_cfg_pkg::row_t nb [0:D-1];
		int n;
		for (int y = 0; y < D; y++) begin
			for (int x = 0; x < W; x++) begin
				n = 0;
				for (int dy = -1; dy <= 1; dy++)
					for (int dx = -1; dx <= 1; dx++)
						if (dy != 0 || dx != 0)
							n += int'(shadow[(y + dy + D) % D][(x + dx + W) % W]);
				nb[y][x] = (n == 3) || (n == 2 && shadow[y][x]);	// birth or survival
			end
		end
		shadow = nb;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// table construction, model tracks every entry
	////////////////////////////////////////////////////////////////////////////

	function automatic void add_test(string name, life_cmd_pkg::cmd_op_e op, int addr,
			life_cfg_pkg::row_t data, logic stall);
		t_name[n_tests]  = name;
		t_op[n_tests]    = op;
		t_addr[n_tests]  = life_cfg_pkg::addr_t'(addr);
		t_data[n_tests]  = data;
		t_stall[n_tests] = stall;
		if (op == life_cmd_pkg::op_write)
			shadow[addr] = data;
		if (op == life_cmd_pkg::op_step)
			for (int g = 0; g < G; g++)
				life_generation();
		t_exp[n_tests] = shadow[addr];	// only used by reads
		n_tests++;
	endfunction

	// step then read the whole board, first read is held by the pass
	function automatic void step_and_read(string tag);
		add_test({tag, " step"}, life_cmd_pkg::op_step, 0, '0, 1'b0);
		for (int y = 0; y < D; y++)
			add_test($sformatf("%s row %0d", tag, y), life_cmd_pkg::op_read, y, '0, y == 0);
	endfunction

	function automatic void clear_board(string tag);
		for (int y = 0; y < D; y++)
			add_test($sformatf("%s clear %0d", tag, y), life_cmd_pkg::op_write, y, '0, 1'b0);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// command driver
	////////////////////////////////////////////////////////////////////////////

	// called 2 ns after an edge, returns 2 ns after the accepting edge
	task automatic send_cmd(input int i, output int stall);
		cmd_valid = 1'b1;
		cmd_op    = t_op[i];
		cmd_addr  = t_addr[i];
		cmd_data  = t_data[i];
		stall     = 0;
		while (!cmd_ready && stall <= PASS_MAX) begin	// held until taken
			@(posedge clk);
			#2;
			stall++;
		end
		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
		cmd_op    = life_cmd_pkg::op_nop;
	endtask

	initial begin
		int   stall;
		logic ok;
		rst       = 1'b1;
		cmd_valid = 1'b0;
		cmd_op    = life_cmd_pkg::op_nop;
		cmd_addr  = '0;
		cmd_data  = '0;

		// write/read and random board over three passes
		for (int y = 0; y < D; y++)
			add_test($sformatf("rand wr %0d", y), life_cmd_pkg::op_write, y, random_row(), 1'b0);
		for (int y = 0; y < D; y++)
			add_test($sformatf("rand rd %0d", y), life_cmd_pkg::op_read, y, '0, 1'b0);
		for (int s = 0; s < 3; s++)
			step_and_read($sformatf("rand pass %0d", s));
		// block at rows 2..3, blinker in row 8
		clear_board("still");
		add_test("block top", life_cmd_pkg::op_write, 2, 16'h000c, 1'b0);
		add_test("block bot", life_cmd_pkg::op_write, 3, 16'h000c, 1'b0);
		add_test("blinker", life_cmd_pkg::op_write, 8, 16'h0380, 1'b0);
		step_and_read("still pass");
		// glider heading over the right and bottom edges
		clear_board("glider");
		add_test("glider r13", life_cmd_pkg::op_write, 13, 16'h4000, 1'b0);
		add_test("glider r14", life_cmd_pkg::op_write, 14, 16'h8000, 1'b0);
		add_test("glider r15", life_cmd_pkg::op_write, 15, 16'he000, 1'b0);
		for (int s = 0; s < 4; s++)
			step_and_read($sformatf("glider pass %0d", s));
		cycle_limit = n_tests * PASS_MAX + 20;

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		if (!cmd_ready || rsp_valid) begin
			$display("FAIL reset: cmd_ready low or rsp_valid high after reset");
			errors++;
		end

		for (int i = 0; i < n_tests; i++) begin
			ok = 1'b1;
			send_cmd(i, stall);
			if (stall > PASS_MAX) begin
				$display("FAIL %s: cmd_ready stayed low, command never accepted", t_name[i]);
				ok = 1'b0;
			end else if (t_stall[i] && stall == 0) begin
				$display("FAIL %s: read was accepted while the pass was running", t_name[i]);
				ok = 1'b0;
			end else if (!t_stall[i] && stall != 0) begin
				$display("FAIL %s: cmd_ready was low with no pass running", t_name[i]);
				ok = 1'b0;
			end
			if (t_op[i] == life_cmd_pkg::op_step && cmd_ready) begin
				$display("FAIL %s: cmd_ready still high after step accepted", t_name[i]);
				ok = 1'b0;
			end
			if (t_op[i] == life_cmd_pkg::op_read) begin
				@(posedge clk);
				#2;	// response register now loaded
				if (!rsp_valid) begin
					$display("FAIL %s: no rsp_valid two cycles after the read", t_name[i]);
					ok = 1'b0;
				end else if (rsp_data !== t_exp[i]) begin
					$display("FAIL %s: expected %h actual %h", t_name[i], t_exp[i], rsp_data);
					ok = 1'b0;
				end
			end
			if (ok)
				$display("PASS %s", t_name[i]);
			else
				errors++;
		end

		$display("%0d tests run, %0d passed, %0d failed", n_tests, n_tests - errors, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: sim.f
common/life_cfg_pkg.sv
common/life_cmd_pkg.sv
rtl/cell_ram.sv
rtl/row_sequencer.sv
life_core/life_gen_stage.sv
life_core/row_writeback.sv
rtl/life_engine_top.sv
verification/life_properties.sv
verification/life_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the Life engine testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module life_tb \
	-Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vlife_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
